//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_deparser
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) test/tb_model.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+test
design/deparser_pkg.sv
design/ctrl_pkg.sv
design/ctrl_table_writer.sv
design/action_table.sv
design/container_select.sv
design/header_rewriter.sv
design/deparser_top.sv
test/tb_deparser.sv

//--- design/action_table.sv
`timescale 1ns/10ps

module action_table (
    input  logic                    clk,
    input  logic                    aresetn,
    input  ctrl_pkg::tbl_wr_t       tbl_wr,
    input  deparser_pkg::tbl_addr_t rd_addr,
    output deparser_pkg::entry_t    rd_entry
);

    import deparser_pkg::*;

    entry_t mem [tbl_depth];

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < tbl_depth; i++) begin
                mem[i] <= '0;
            end
            rd_entry <= '0;
        end else begin
            if (tbl_wr.en) begin
                mem[tbl_wr.addr] <= tbl_wr.entry;
            end
            // read before write on a shared address
            rd_entry <= mem[rd_addr];
        end
    end

    assert property (@(posedge clk) disable iff (!aresetn)
        !$isunknown(rd_addr));

endmodule

//--- design/container_select.sv
`timescale 1ns/10ps

module container_select (
    input  logic                      clk,
    input  logic                      aresetn,
    input  deparser_pkg::phv_t        phv,
    input  deparser_pkg::action_t     action,
    input  logic                      sel_en,
    output deparser_pkg::cont_field_t field
);

    import deparser_pkg::*;

    cont_size_e size_c;
    cont_val_t  value_c;
    logic [1:0] idx;

    assign idx    = action[act_idx_lsb +: 2];
    assign size_c = action[act_valid_bit] ? cont_size_e'(action[act_size_lsb +: 2]) : sz_none;

    // left align so the first byte on the wire is value[47:40]
    always_comb begin
        case (size_c)
            sz_two:  value_c = {phv[phv_2b_lsb + 16 * idx +: 16], 32'b0};
            sz_four: value_c = {phv[phv_4b_lsb + 32 * idx +: 32], 16'b0};
            sz_six:  value_c = phv[phv_6b_lsb + 48 * idx +: 48];
            default: value_c = '0;
        endcase
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            field <= '0;
        end else if (sel_en) begin
            field.value  <= value_c;
            field.size   <= size_c;
            field.offset <= action[act_off_lsb +: 6];
        end
    end

    // edits must fit inside the header beat
    assert property (@(posedge clk) disable iff (!aresetn)
        field.size != sz_none |-> int'(field.offset) + cont_bytes(field.size) <= keep_w);

endmodule

//--- design/ctrl_pkg.sv
package ctrl_pkg;

    // this deparser's id, compared with the low 3 bits of the id byte
    localparam logic [2:0] deparser_id = 3'b101;

    localparam int mod_id_lsb = 368;
    localparam int flag_lsb   = 320;
    localparam int index_lsb  = 384;

    localparam logic [15:0] ctrl_flag = 16'hf2f1;

    typedef struct packed {
        logic                   en;
        deparser_pkg::tbl_addr_t addr;
        deparser_pkg::entry_t    entry;
    } tbl_wr_t;

endpackage

//--- design/ctrl_table_writer.sv
`timescale 1ns/10ps

module ctrl_table_writer (
    input  logic                  clk,
    input  logic                  aresetn,
    input  deparser_pkg::data_t   c_s_axis,
    input  logic                  c_s_axis_valid,
    input  logic                  c_s_axis_last,
    output ctrl_pkg::tbl_wr_t     tbl_wr
);

    import deparser_pkg::*;
    import ctrl_pkg::*;

    typedef enum logic [1:0] {
        c_idle,
        c_first_wr,
        c_next_wr
    } ctrl_state_e;

    ctrl_state_e state;
    data_t       swapped;
    logic        hdr_match;

    // control beats arrive little endian, entries are stored big endian
    always_comb begin
        for (int b = 0; b < data_w / 8; b++) begin
            swapped[data_w - 8 - 8 * b +: 8] = c_s_axis[8 * b +: 8];
        end
    end

    assign hdr_match = c_s_axis_valid
                    && c_s_axis[mod_id_lsb +: 3] == deparser_id
                    && c_s_axis[flag_lsb +: 16] == ctrl_flag;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state  <= c_idle;
            tbl_wr <= '0;
        end else begin
            tbl_wr.en <= 1'b0;
            case (state)
                c_idle: begin
                    if (hdr_match && !c_s_axis_last) begin
                        tbl_wr.addr <= c_s_axis[index_lsb +: tbl_addr_w];
                        state       <= c_first_wr;
                    end
                end
                c_first_wr, c_next_wr: begin
                    if (c_s_axis_valid) begin
                        tbl_wr.en    <= 1'b1;
                        tbl_wr.entry <= swapped[data_w-1 -: entry_w];
                        // first entry lands on the start index itself
                        if (state == c_next_wr) begin
                            tbl_wr.addr <= tbl_wr.addr + 1'b1;
                        end
                        state <= c_s_axis_last ? c_idle : c_next_wr;
                    end
                end
                default: state <= c_idle;
            endcase
        end
    end

    // a write seen in idle is the tail of an entry burst
    assert property (@(posedge clk) disable iff (!aresetn)
        (state == c_idle && tbl_wr.en) |-> $past(state != c_idle && c_s_axis_valid));

endmodule

//--- design/deparser_pkg.sv
package deparser_pkg;

    localparam int data_w    = 512;
    localparam int keep_w    = data_w / 8;
    localparam int user_w    = 128;
    localparam int n_actions = 4;
    localparam int n_cont    = 4;
    localparam int tbl_depth = 16;

    localparam int action_w     = 16;
    localparam int entry_w      = n_actions * action_w;
    localparam int tbl_addr_w   = 4;
    localparam int cont_val_w   = 48;
    localparam int cont_max_bytes = cont_val_w / 8;

    // phv groups, smallest containers at the bottom
    localparam int phv_2b_lsb = 0;
    localparam int phv_4b_lsb = phv_2b_lsb + n_cont * 16;
    localparam int phv_6b_lsb = phv_4b_lsb + n_cont * 32;
    localparam int phv_w      = phv_6b_lsb + n_cont * 48;

    // action word fields
    localparam int act_off_lsb   = 6;
    localparam int act_size_lsb  = 4;
    localparam int act_idx_lsb   = 1;
    localparam int act_valid_bit = 0;

    // vlan id in the first beat, table address is vlan[7:4]
    localparam int vlan_lsb      = 116;
    localparam int vlan_addr_lsb = vlan_lsb + 4;

    typedef logic [data_w-1:0]     data_t;
    typedef logic [keep_w-1:0]     keep_t;
    typedef logic [user_w-1:0]     user_t;
    typedef logic [phv_w-1:0]      phv_t;
    typedef logic [action_w-1:0]   action_t;
    typedef logic [entry_w-1:0]    entry_t;
    typedef logic [tbl_addr_w-1:0] tbl_addr_t;
    typedef logic [cont_val_w-1:0] cont_val_t;

    typedef enum logic [1:0] {
        sz_none,
        sz_two,
        sz_four,
        sz_six
    } cont_size_e;

    typedef struct packed {
        data_t data;
        keep_t keep;
        user_t user;
        logic  last;
    } pkt_beat_t;

    typedef struct packed {
        cont_val_t  value;
        cont_size_e size;
        logic [5:0] offset;
    } cont_field_t;

    function automatic int cont_bytes(cont_size_e size);
        case (size)
            sz_two:  return 2;
            sz_four: return 4;
            sz_six:  return 6;
            default: return 0;
        endcase
    endfunction

endpackage

//--- design/deparser_top.sv
`timescale 1ns/10ps

module deparser_top (
    input  logic                    clk,
    input  logic                    aresetn,
    input  deparser_pkg::pkt_beat_t pkt_fifo,
    input  logic                    pkt_fifo_empty,
    output logic                    pkt_fifo_rd_en,
    input  deparser_pkg::phv_t      phv_fifo,
    input  logic                    phv_fifo_empty,
    output logic                    phv_fifo_rd_en,
    output deparser_pkg::pkt_beat_t depar_out,
    output logic                    depar_out_valid,
    input  logic                    depar_out_ready,
    input  deparser_pkg::data_t     c_s_axis,
    input  logic                    c_s_axis_valid,
    input  logic                    c_s_axis_last
);

    import deparser_pkg::*;
    import ctrl_pkg::*;

    tbl_wr_t     tbl_wr;
    tbl_addr_t   rd_addr;
    entry_t      rd_entry;
    phv_t        phv_q;
    action_t     actions [n_actions];
    logic        sel_en;
    cont_field_t fields [n_actions];

    ctrl_table_writer u_ctrl (
        .clk            (clk),
        .aresetn        (aresetn),
        .c_s_axis       (c_s_axis),
        .c_s_axis_valid (c_s_axis_valid),
        .c_s_axis_last  (c_s_axis_last),
        .tbl_wr         (tbl_wr)
    );

    action_table u_table (
        .clk      (clk),
        .aresetn  (aresetn),
        .tbl_wr   (tbl_wr),
        .rd_addr  (rd_addr),
        .rd_entry (rd_entry)
    );

    // one selector per action slot
    for (genvar i = 0; i < n_actions; i++) begin : g_sel
        container_select u_sel (
            .clk     (clk),
            .aresetn (aresetn),
            .phv     (phv_q),
            .action  (actions[i]),
            .sel_en  (sel_en),
            .field   (fields[i])
        );
    end

    header_rewriter u_rewriter (
        .clk             (clk),
        .aresetn         (aresetn),
        .pkt_fifo        (pkt_fifo),
        .pkt_fifo_empty  (pkt_fifo_empty),
        .phv_fifo        (phv_fifo),
        .phv_fifo_empty  (phv_fifo_empty),
        .pkt_fifo_rd_en  (pkt_fifo_rd_en),
        .phv_fifo_rd_en  (phv_fifo_rd_en),
        .rd_addr         (rd_addr),
        .rd_entry        (rd_entry),
        .phv_q           (phv_q),
        .actions         (actions),
        .sel_en          (sel_en),
        .fields          (fields),
        .depar_out       (depar_out),
        .depar_out_valid (depar_out_valid),
        .depar_out_ready (depar_out_ready)
    );

endmodule

//--- design/header_rewriter.sv
`timescale 1ns/10ps

module header_rewriter (
    input  logic                      clk,
    input  logic                      aresetn,
    input  deparser_pkg::pkt_beat_t   pkt_fifo,
    input  logic                      pkt_fifo_empty,
    input  deparser_pkg::phv_t        phv_fifo,
    input  logic                      phv_fifo_empty,
    output logic                      pkt_fifo_rd_en,
    output logic                      phv_fifo_rd_en,
    output deparser_pkg::tbl_addr_t   rd_addr,
    input  deparser_pkg::entry_t      rd_entry,
    output deparser_pkg::phv_t        phv_q,
    output deparser_pkg::action_t     actions [deparser_pkg::n_actions],
    output logic                      sel_en,
    input  deparser_pkg::cont_field_t fields [deparser_pkg::n_actions],
    output deparser_pkg::pkt_beat_t   depar_out,
    output logic                      depar_out_valid,
    input  logic                      depar_out_ready
);

    import deparser_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_select,
        st_rewrite,
        st_send_hdr,
        st_flush
    } depar_state_e;

    depar_state_e state;
    pkt_beat_t    hdr_q;
    data_t        hdr_edit;
    logic         start;
    logic         accept;
    logic         more_beats;
    logic         pop_beat;

    assign start  = state == st_idle && !pkt_fifo_empty && !phv_fifo_empty;
    assign accept = depar_out_valid && depar_out_ready;

    // the tail is in the output register once a last beat is loaded
    assign more_beats = (state == st_send_hdr || state == st_flush)
                     && !(depar_out_valid && depar_out.last);
    assign pop_beat   = more_beats && !pkt_fifo_empty && (!depar_out_valid || depar_out_ready);

    assign pkt_fifo_rd_en = start || pop_beat;
    assign phv_fifo_rd_en = start;

    // entry is on rd_entry during select, the selectors sample it there
    assign sel_en = state == st_select;

    always_comb begin
        for (int a = 0; a < n_actions; a++) begin
            actions[a] = rd_entry[(n_actions - 1 - a) * action_w +: action_w];
        end
    end

    // msb byte of a container goes to the lowest lane, later actions win
    always_comb begin
        hdr_edit = hdr_q.data;
        for (int a = 0; a < n_actions; a++) begin
            for (int k = 0; k < cont_max_bytes; k++) begin
                if (k < cont_bytes(fields[a].size) && int'(fields[a].offset) + k < keep_w) begin
                    hdr_edit[(int'(fields[a].offset) + k) * 8 +: 8] =
                        fields[a].value[cont_val_w - 1 - 8 * k -: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state           <= st_idle;
            rd_addr         <= '0;
            depar_out_valid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        rd_addr <= pkt_fifo.data[vlan_addr_lsb +: tbl_addr_w];
                        state   <= st_lookup;
                    end
                end
                st_lookup:  state <= st_select;
                st_select:  state <= st_rewrite;
                st_rewrite: state <= st_send_hdr;
                st_send_hdr: begin
                    if (accept) begin
                        state <= depar_out.last ? st_idle : st_flush;
                    end
                end
                st_flush: begin
                    if (accept && depar_out.last) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase

            if (state == st_rewrite || pop_beat) begin
                depar_out_valid <= 1'b1;
            end else if (depar_out_ready) begin
                depar_out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            hdr_q <= pkt_fifo;
            phv_q <= phv_fifo;
        end
        if (state == st_rewrite) begin
            depar_out <= '{data: hdr_edit, keep: hdr_q.keep, user: hdr_q.user, last: hdr_q.last};
        end else if (pop_beat) begin
            depar_out <= pkt_fifo;
        end
    end

    assert property (@(posedge clk) disable iff (!aresetn)
        depar_out_valid && !depar_out_ready |=> depar_out_valid && $stable(depar_out));

endmodule

//--- test/tb_model.svh
// shadow of the action table, written only by accepted control packets
entry_t shadow [tbl_depth];

function automatic data_t rand_data();
    data_t d;
    for (int w = 0; w < data_w / 32; w++) begin
        d[32 * w +: 32] = $random(seed);
    end
    return d;
endfunction

// size code 1, 2, 3 means 2, 4, 6 bytes
function automatic int size_bytes(logic [1:0] code);
    return (code == 2'd0) ? 0 : 2 * int'(code);
endfunction

function automatic action_t make_action(logic valid, logic [1:0] size, logic [1:0] idx,
                                        logic [5:0] off);
    return {4'b0, off, size, 1'b0, idx, valid};
endfunction

// valid actions that always fit inside the beat
function automatic entry_t rand_entry();
    entry_t      e;
    logic [31:0] r;
    logic [1:0]  size;
    for (int a = 0; a < n_actions; a++) begin
        r = $random(seed);
        size = (r[1:0] == 2'd0) ? 2'd3 : r[1:0];
        e[16 * a +: 16] = make_action(1'b1, size, r[3:2],
                                      6'(int'(r[15:8]) % (65 - size_bytes(size))));
    end
    return e;
endfunction

// byte k of a container, msb first, lands on lane offset + k
function automatic data_t rewrite_hdr(data_t d, entry_t e, phv_t p);
    action_t act;
    int      nb;
    int      base;
    for (int a = 0; a < n_actions; a++) begin
        act = e[entry_w - 16 * (a + 1) +: 16];
        nb = act[0] ? size_bytes(act[5:4]) : 0;
        base = (nb == 2) ? 0 : (nb == 4) ? 64 : 192;
        base += 8 * nb * int'(act[2:1]);
        for (int k = 0; k < nb; k++) begin
            d[(int'(act[11:6]) + k) * 8 +: 8] = p[base + 8 * (nb - 1 - k) +: 8];
        end
    end
    return d;
endfunction

function automatic data_t ctrl_header(logic [2:0] id, logic [15:0] flag, logic [7:0] start);
    data_t d;
    d = rand_data();
    d[mod_id_lsb +: 8] = {5'b0, id};
    d[flag_lsb +: 16] = flag;
    d[index_lsb +: 8] = start;
    return d;
endfunction

// entry goes out lowest lane first, msb byte in lane 0
function automatic data_t ctrl_entry(entry_t e);
    data_t d;
    d = rand_data();
    for (int b = 0; b < entry_w / 8; b++) begin
        d[8 * b +: 8] = e[entry_w - 8 - 8 * b +: 8];
    end
    return d;
endfunction

function automatic pkt_beat_t make_beat(logic last);
    pkt_beat_t b;
    data_t     side;
    b.data = rand_data();
    side = rand_data();
    b.keep = side[keep_w-1:0];
    b.user = side[keep_w +: user_w];
    b.last = last;
    return b;
endfunction

//--- test/tb_deparser.sv
`timescale 1ns/10ps

module tb_deparser;

    import deparser_pkg::*;
    import ctrl_pkg::*;

    logic      clk = 1'b0;
    logic      aresetn = 1'b0;
    pkt_beat_t pkt_fifo = '0;
    logic      pkt_fifo_empty = 1'b1;
    logic      pkt_fifo_rd_en;
    phv_t      phv_fifo = '0;
    logic      phv_fifo_empty = 1'b1;
    logic      phv_fifo_rd_en;
    pkt_beat_t depar_out;
    logic      depar_out_valid;
    logic      depar_out_ready = 1'b0;
    data_t     c_s_axis = '0;
    logic      c_s_axis_valid = 1'b0;
    logic      c_s_axis_last = 1'b0;

    int          seed = 32'hc9e84616;
    logic [31:0] rnd;
    pkt_beat_t   pkt_q [$];
    phv_t        phv_q [$];
    pkt_beat_t   exp_q [$];
    entry_t      ctrl_ents [$];
    pkt_beat_t   exp_head = '0;
    logic        exp_empty = 1'b1;
    logic        pkt_pop = 1'b0;
    logic        phv_pop = 1'b0;
    logic        out_acc = 1'b0;
    logic        rand_ready = 1'b0;
    logic        quiet = 1'b0;
    string       test_name = "reset";
    int          errors = 0;
    int          timeouts = 0;
    int          errs_before = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          beats_checked = 0;

    `include "tb_model.svh"

    deparser_top u_dut (.*);

    always #5 clk = ~clk;

    // pops and accepts are settled by the falling edge
    always @(negedge clk) begin
        pkt_pop = pkt_fifo_rd_en;
        phv_pop = phv_fifo_rd_en;
        out_acc = depar_out_valid && depar_out_ready;
    end

    // fwft fifo models and expected queue
    always @(posedge clk) begin
        #1;
        if (pkt_pop && pkt_q.size() > 0) void'(pkt_q.pop_front());
        if (phv_pop && phv_q.size() > 0) void'(phv_q.pop_front());
        if (out_acc && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            beats_checked++;
        end
        pkt_fifo_empty = pkt_q.size() == 0;
        pkt_fifo = pkt_fifo_empty ? '0 : pkt_q[0];
        phv_fifo_empty = phv_q.size() == 0;
        phv_fifo = phv_fifo_empty ? '0 : phv_q[0];
        exp_empty = exp_q.size() == 0;
        exp_head = exp_empty ? '0 : exp_q[0];
    end

    always @(posedge clk) begin
        #1;
        if (rand_ready) begin
            rnd = $random(seed);
            depar_out_ready = rnd[0];
        end else begin
            depar_out_ready = 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!aresetn)
        depar_out_valid && depar_out_ready && !exp_empty |-> depar_out == exp_head)
    else begin
        $display("MISMATCH %s expected %h actual %h", test_name,
                 $sampled(exp_head), $sampled(depar_out));
        errors++;
    end

    assert property (@(posedge clk) disable iff (!aresetn)
        depar_out_valid && depar_out_ready |-> !exp_empty)
    else begin
        $display("%s: an output beat arrived when none was expected", test_name);
        errors++;
    end

    assert property (@(posedge clk) disable iff (!aresetn)
        depar_out_valid && !depar_out_ready |=> depar_out_valid && $stable(depar_out))
    else begin
        $display("%s: the output beat changed or vanished while stalled", test_name);
        errors++;
    end

    assert property (@(posedge clk) disable iff (!aresetn)
        !(pkt_fifo_empty && pkt_fifo_rd_en) && !(phv_fifo_empty && phv_fifo_rd_en))
    else begin
        $display("%s: a FIFO was read while empty", test_name);
        errors++;
    end

    assert property (@(posedge clk) disable iff (!aresetn)
        quiet |-> !depar_out_valid && !pkt_fifo_rd_en && !phv_fifo_rd_en)
    else begin
        $display("%s: output or reads active with both FIFOs empty", test_name);
        errors++;
    end

    task automatic start_test(string name);
        @(negedge clk);
        test_name = name;
        errs_before = errors + timeouts;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((pkt_q.size() > 0 || phv_q.size() > 0 || exp_q.size() > 0) && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (pkt_q.size() > 0 || phv_q.size() > 0 || exp_q.size() > 0) begin
            $display("%s: timed out waiting for the output to drain", test_name);
            timeouts++;
        end
    endtask

    task automatic end_test();
        int n;
        wait_drain();
        n = errors + timeouts - errs_before;
        tests_run++;
        if (n > 0) tests_bad++;
        $display("%-10s finished, %0d errors", test_name, n);
    endtask

    // header beat, then one beat per entry in ctrl_ents
    task automatic write_ctrl(logic [2:0] id, logic [15:0] flag, logic [7:0] start);
        data_t beats [$];
        @(negedge clk);
        beats.push_back(ctrl_header(id, flag, start));
        foreach (ctrl_ents[i]) begin
            beats.push_back(ctrl_entry(ctrl_ents[i]));
            if (id == 3'b101 && flag == 16'hf2f1) shadow[4'(start + i)] = ctrl_ents[i];
        end
        foreach (beats[b]) begin
            @(posedge clk);
            #1;
            c_s_axis = beats[b];
            c_s_axis_valid = 1'b1;
            c_s_axis_last = b == beats.size() - 1;
        end
        @(posedge clk);
        #1;
        c_s_axis_valid = 1'b0;
        c_s_axis_last = 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic send_packet(tbl_addr_t idx, int nbeats);
        pkt_beat_t b;
        data_t     tmp;
        phv_t      p;
        @(negedge clk);
        tmp = rand_data();
        p = tmp[phv_w-1:0];
        for (int i = 0; i < nbeats; i++) begin
            b = make_beat(i == nbeats - 1);
            if (i == 0) b.data[vlan_lsb + 4 +: 4] = idx;
            pkt_q.push_back(b);
            if (i == 0) b.data = rewrite_hdr(b.data, shadow[idx], p);
            exp_q.push_back(b);
        end
        phv_q.push_back(p);
    endtask

    initial begin
        repeat (4) @(posedge clk);
        #1;
        aresetn = 1'b1;

        start_test("reset");
        quiet = 1'b1;
        repeat (10) @(negedge clk);
        quiet = 1'b0;
        end_test();

        // all sixteen entries, start index wraps past 15
        start_test("single");
        for (int i = 0; i < tbl_depth; i++) ctrl_ents.push_back(rand_entry());
        write_ctrl(3'b101, 16'hf2f1, 8'hf3);
        send_packet(4'd3, 1);
        send_packet(4'd2, 1);
        end_test();

        start_test("multi");
        send_packet(4'd7, 4);
        send_packet(4'd0, 2);
        end_test();

        start_test("backpress");
        rand_ready = 1'b1;
        for (int k = 0; k < 6; k++) send_packet(4'(k * 5), 1 + k % 4);
        end_test();
        rand_ready = 1'b0;

        start_test("filter");
        ctrl_ents.delete();
        ctrl_ents.push_back(rand_entry());
        write_ctrl(3'b011, 16'hf2f1, 8'h06);
        write_ctrl(3'b101, 16'hf2f0, 8'h06);
        send_packet(4'd6, 2);
        end_test();

        // invalid actions at 12, overlapping ones at 13
        start_test("edge_acts");
        ctrl_ents.delete();
        ctrl_ents.push_back({make_action(1'b0, 2'd3, 2'd1, 6'd10),
                             make_action(1'b1, 2'd0, 2'd2, 6'd20),
                             make_action(1'b1, 2'd2, 2'd3, 6'd0),
                             make_action(1'b0, 2'd1, 2'd0, 6'd40)});
        ctrl_ents.push_back({make_action(1'b1, 2'd3, 2'd0, 6'd8),
                             make_action(1'b1, 2'd2, 2'd2, 6'd10),
                             make_action(1'b1, 2'd1, 2'd3, 6'd12),
                             make_action(1'b1, 2'd3, 2'd3, 6'd58)});
        write_ctrl(3'b101, 16'hf2f1, 8'h0c);
        send_packet(4'd12, 1);
        send_packet(4'd13, 3);
        end_test();

        $display("summary: %0d tests, %0d with errors, %0d beats checked, %0d errors",
                 tests_run, tests_bad, beats_checked, errors + timeouts);
        if (errors + timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
